// File: chiplet_types_pkg.sv
package chiplet_types_pkg;

    // Flit payload width
    localparam int FLIT_WIDTH = 32;

    // Format field, top nibble of every flit
    localparam int FMT_MSB = 31;
    localparam int FMT_LSB = 28;

    // Destination node of any flit
    localparam int DEST_MSB = 27;
    localparam int DEST_LSB = 23;

    // Config flit, node whose route entry or id is written
    localparam int CFG_NODE_MSB = 22;
    localparam int CFG_NODE_LSB = 18;

    // Config flit, output port stored in the route entry
    localparam int CFG_PORT_MSB = 17;
    localparam int CFG_PORT_LSB = 16;

    // Config flit loads the node id instead of a route
    localparam int CFG_SET_ID_BIT = 15;

    // Format encodings
    localparam logic [FMT_MSB-FMT_LSB:0] FMT_DATA = 4'd1;
    localparam logic [FMT_MSB-FMT_LSB:0] FMT_SWITCH_CFG = 4'd4;

    typedef logic [FLIT_WIDTH-1:0] flit_t;

endpackage

// File: flit_fifo.sv
`timescale 1ns/10ps

module flit_fifo (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     wr_en,
    input  chiplet_types_pkg::flit_t wr_data,
    input  logic                     rd_en,
    output chiplet_types_pkg::flit_t rd_data,
    output logic                     empty,
    output logic                     full
);
    chiplet_types_pkg::flit_t mem [switch_cfg_pkg::BUFFER_DEPTH];
    logic [switch_cfg_pkg::PTR_BITS-1:0] wr_ptr;
    logic [switch_cfg_pkg::PTR_BITS-1:0] rd_ptr;
    logic [switch_cfg_pkg::COUNT_BITS-1:0] count;
    logic do_wr;
    logic do_rd;

    // Circular increment, also correct for depths that are not a power of two
    function automatic logic [switch_cfg_pkg::PTR_BITS-1:0] next_ptr(
        input logic [switch_cfg_pkg::PTR_BITS-1:0] ptr
    );
        if (int'(ptr) == switch_cfg_pkg::BUFFER_DEPTH - 1) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full = (int'(count) == switch_cfg_pkg::BUFFER_DEPTH);
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    // Head is visible without a read cycle
    assign rd_data = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end
endmodule

// File: input_unit.sv
`timescale 1ns/10ps

module input_unit (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  chiplet_types_pkg::flit_t             in_flit,
    input  logic                                 in_valid,
    input  logic [switch_cfg_pkg::PORT_BITS-1:0] lookup_port,
    input  logic                                 cfg_claim,
    input  logic                                 grant,
    output logic                                 in_ready,
    output logic [switch_cfg_pkg::NODE_BITS-1:0] lookup_node,
    output logic                                 cfg_valid,
    output chiplet_types_pkg::flit_t             cfg_flit,
    output logic                                 req,
    output logic [switch_cfg_pkg::PORT_BITS-1:0] req_port,
    output chiplet_types_pkg::flit_t             head_flit
);
    chiplet_types_pkg::flit_t head;
    logic [chiplet_types_pkg::FMT_MSB-chiplet_types_pkg::FMT_LSB:0] head_fmt;
    logic empty;
    logic full;
    logic is_data;
    logic is_cfg;
    logic is_other;
    logic pop;

    flit_fifo i_fifo (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (in_valid),
        .wr_data (in_flit),
        .rd_en   (pop),
        .rd_data (head),
        .empty   (empty),
        .full    (full)
    );

    assign in_ready = !full;

    // Head format decode
    assign head_fmt = head[chiplet_types_pkg::FMT_MSB:chiplet_types_pkg::FMT_LSB];
    assign is_data = !empty && (head_fmt == chiplet_types_pkg::FMT_DATA);
    assign is_cfg = !empty && (head_fmt == chiplet_types_pkg::FMT_SWITCH_CFG);

    // Unknown formats would block the port forever
    assign is_other = !empty && !is_data && !is_cfg;

    // Route lookup on the head destination
    assign lookup_node = head[chiplet_types_pkg::DEST_MSB:chiplet_types_pkg::DEST_LSB];

    // Config heads go to the route table
    assign cfg_valid = is_cfg;
    assign cfg_flit = head;

    // Data heads request their routed output
    assign req = is_data;
    assign req_port = lookup_port;
    assign head_flit = head;

    assign pop = (is_data && grant) || (is_cfg && cfg_claim) || is_other;
endmodule

// File: output_crossbar.sv
`timescale 1ns/10ps

module output_crossbar (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 req [switch_cfg_pkg::NUM_PORTS],
    input  logic [switch_cfg_pkg::PORT_BITS-1:0] req_port [switch_cfg_pkg::NUM_PORTS],
    input  chiplet_types_pkg::flit_t             head_flit [switch_cfg_pkg::NUM_PORTS],
    input  logic                                 out_ready [switch_cfg_pkg::NUM_PORTS],
    output logic                                 grant [switch_cfg_pkg::NUM_PORTS],
    output chiplet_types_pkg::flit_t             out_flit [switch_cfg_pkg::NUM_PORTS],
    output logic                                 out_valid [switch_cfg_pkg::NUM_PORTS]
);
    logic [switch_cfg_pkg::PORT_BITS-1:0] rr_ptr [switch_cfg_pkg::NUM_PORTS];
    logic [switch_cfg_pkg::PORT_BITS-1:0] win [switch_cfg_pkg::NUM_PORTS];
    logic found [switch_cfg_pkg::NUM_PORTS];
    logic load_ok [switch_cfg_pkg::NUM_PORTS];

    // Output register is free or drains this cycle
    always_comb begin
        for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
            load_ok[o] = !out_valid[o] || out_ready[o];
        end
    end

    // Round-robin search per output, starting at its pointer
    always_comb begin
        int idx;
        idx = 0;
        for (int i = 0; i < switch_cfg_pkg::NUM_PORTS; i++) begin
            grant[i] = 1'b0;
        end
        for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
            found[o] = 1'b0;
            win[o] = '0;
            if (load_ok[o]) begin
                for (int k = 0; k < switch_cfg_pkg::NUM_PORTS; k++) begin
                    idx = (int'(rr_ptr[o]) + k) % switch_cfg_pkg::NUM_PORTS;
                    if (!found[o] && req[idx] && int'(req_port[idx]) == o) begin
                        found[o] = 1'b1;
                        win[o] = idx[switch_cfg_pkg::PORT_BITS-1:0];
                    end
                end
            end
            // Each input asks for one output only
            if (found[o]) begin
                grant[win[o]] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
                out_valid[o] <= 1'b0;
                rr_ptr[o] <= '0;
            end
        end else begin
            for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
                if (load_ok[o]) begin
                    out_valid[o] <= found[o];
                end
                // Pointer moves one past the winner
                if (found[o]) begin
                    if (int'(win[o]) == switch_cfg_pkg::NUM_PORTS - 1) begin
                        rr_ptr[o] <= '0;
                    end else begin
                        rr_ptr[o] <= win[o] + 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
            if (found[o]) begin
                out_flit[o] <= head_flit[win[o]];
            end
        end
    end
endmodule

// File: project.f
chiplet_types_pkg.sv
switch_cfg_pkg.sv
flit_fifo.sv
route_table.sv
input_unit.sv
output_crossbar.sv
switch.sv
tb_switch.sv

// File: route_table.sv
`timescale 1ns/10ps

module route_table (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic [switch_cfg_pkg::NODE_BITS-1:0] lookup_node [switch_cfg_pkg::NUM_PORTS],
    input  logic                                 cfg_valid [switch_cfg_pkg::NUM_PORTS],
    input  chiplet_types_pkg::flit_t             cfg_flit [switch_cfg_pkg::NUM_PORTS],
    output logic [switch_cfg_pkg::PORT_BITS-1:0] lookup_port [switch_cfg_pkg::NUM_PORTS],
    output logic                                 cfg_claim [switch_cfg_pkg::NUM_PORTS],
    output logic [switch_cfg_pkg::NODE_BITS-1:0] node_id
);
    logic [switch_cfg_pkg::PORT_BITS-1:0] route [switch_cfg_pkg::TOTAL_NODES];
    chiplet_types_pkg::flit_t sel_flit;
    logic cfg_any;
    logic addressed;
    logic [switch_cfg_pkg::NODE_BITS-1:0] cfg_dest;
    logic [switch_cfg_pkg::NODE_BITS-1:0] cfg_node;

    // Combinational lookup for every input head
    always_comb begin
        for (int i = 0; i < switch_cfg_pkg::NUM_PORTS; i++) begin
            lookup_port[i] = route[lookup_node[i]];
        end
    end

    // Lowest requesting port is served and pops its flit,
    // whether or not the flit turns out to be for this node
    always_comb begin
        cfg_any = 1'b0;
        sel_flit = '0;
        for (int i = 0; i < switch_cfg_pkg::NUM_PORTS; i++) begin
            cfg_claim[i] = 1'b0;
            if (cfg_valid[i] && !cfg_any) begin
                cfg_any = 1'b1;
                sel_flit = cfg_flit[i];
                cfg_claim[i] = 1'b1;
            end
        end
    end

    assign cfg_dest = sel_flit[chiplet_types_pkg::DEST_MSB:chiplet_types_pkg::DEST_LSB];
    assign cfg_node = sel_flit[chiplet_types_pkg::CFG_NODE_MSB:chiplet_types_pkg::CFG_NODE_LSB];

    // An unconfigured node accepts any config flit
    assign addressed = cfg_any && (cfg_dest == node_id || node_id == '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            node_id <= '0;
            for (int n = 0; n < switch_cfg_pkg::TOTAL_NODES; n++) begin
                route[n] <= '0;
            end
        end else if (addressed) begin
            if (sel_flit[chiplet_types_pkg::CFG_SET_ID_BIT]) begin
                node_id <= cfg_node;
            end else begin
                route[cfg_node] <=
                    sel_flit[chiplet_types_pkg::CFG_PORT_MSB:chiplet_types_pkg::CFG_PORT_LSB];
            end
        end
    end
endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the switch testbench, then search the log for the failure line
rm -f sim.log
verilator --binary --timing --top-module tb_switch -f project.f -o sim_switch \
    && ./obj_dir/sim_switch > sim.log 2>&1 \
    || echo "Something failed" >> sim.log
cat sim.log
grep -q "Something failed" sim.log && exit 1 || exit 0

// File: switch.sv
`timescale 1ns/10ps

module switch (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  chiplet_types_pkg::flit_t             in_flit [switch_cfg_pkg::NUM_PORTS],
    input  logic                                 in_valid [switch_cfg_pkg::NUM_PORTS],
    input  logic                                 out_ready [switch_cfg_pkg::NUM_PORTS],
    output logic                                 in_ready [switch_cfg_pkg::NUM_PORTS],
    output chiplet_types_pkg::flit_t             out_flit [switch_cfg_pkg::NUM_PORTS],
    output logic                                 out_valid [switch_cfg_pkg::NUM_PORTS],
    output logic [switch_cfg_pkg::NODE_BITS-1:0] node_id
);
    // Input unit to route table
    logic [switch_cfg_pkg::NODE_BITS-1:0] lookup_node [switch_cfg_pkg::NUM_PORTS];
    logic [switch_cfg_pkg::PORT_BITS-1:0] lookup_port [switch_cfg_pkg::NUM_PORTS];
    logic cfg_valid [switch_cfg_pkg::NUM_PORTS];
    chiplet_types_pkg::flit_t cfg_flit [switch_cfg_pkg::NUM_PORTS];
    logic cfg_claim [switch_cfg_pkg::NUM_PORTS];

    // Input unit to crossbar
    logic req [switch_cfg_pkg::NUM_PORTS];
    logic [switch_cfg_pkg::PORT_BITS-1:0] req_port [switch_cfg_pkg::NUM_PORTS];
    chiplet_types_pkg::flit_t head_flit [switch_cfg_pkg::NUM_PORTS];
    logic grant [switch_cfg_pkg::NUM_PORTS];

    route_table i_route_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_node (lookup_node),
        .cfg_valid   (cfg_valid),
        .cfg_flit    (cfg_flit),
        .lookup_port (lookup_port),
        .cfg_claim   (cfg_claim),
        .node_id     (node_id)
    );

    for (genvar p = 0; p < switch_cfg_pkg::NUM_PORTS; p++) begin : g_input
        input_unit i_input_unit (
            .clk         (clk),
            .rst_n       (rst_n),
            .in_flit     (in_flit[p]),
            .in_valid    (in_valid[p]),
            .lookup_port (lookup_port[p]),
            .cfg_claim   (cfg_claim[p]),
            .grant       (grant[p]),
            .in_ready    (in_ready[p]),
            .lookup_node (lookup_node[p]),
            .cfg_valid   (cfg_valid[p]),
            .cfg_flit    (cfg_flit[p]),
            .req         (req[p]),
            .req_port    (req_port[p]),
            .head_flit   (head_flit[p])
        );
    end

    output_crossbar i_crossbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .req_port  (req_port),
        .head_flit (head_flit),
        .out_ready (out_ready),
        .grant     (grant),
        .out_flit  (out_flit),
        .out_valid (out_valid)
    );
endmodule

// File: switch_cfg_pkg.sv
package switch_cfg_pkg;

    // Port count and index width
    localparam int NUM_PORTS = 4;
    localparam int PORT_BITS = 2;

    // Input buffering, flits per port
    localparam int BUFFER_DEPTH = 4;
    localparam int PTR_BITS = $clog2(BUFFER_DEPTH);
    localparam int COUNT_BITS = $clog2(BUFFER_DEPTH + 1);

    // Route table size and node index width
    localparam int TOTAL_NODES = 32;
    localparam int NODE_BITS = 5;

endpackage

// File: switch_stimulus.txt
# gap input_port flit_hex expected_output out_ready_stall_cycles
# expected_output 7 means the flit leaves no output
2 0 11800001 0 0
0 1 11801002 0 0
0 2 11802003 0 0
0 3 11803004 0 0
4 1 40148000 7 0
3 0 42A60000 7 0
0 2 42B10000 7 0
0 3 42D30000 7 0
0 1 46270000 7 0
0 2 461C8000 7 0
4 0 14800005 2 0
0 1 16001006 1 0
0 2 1A002007 3 0
2 0 14800008 2 30
0 1 14801009 2 0
0 2 1480200A 2 0
0 3 1480300B 2 0
0 0 1480000C 2 0
0 1 1480100D 2 0
0 2 1600200E 1 40
0 3 1A00300F 3 0
0 0 11800010 0 0
0 1 14801011 2 0
1 3 16003012 1 0
0 2 14802013 2 0

// File: tb_switch.sv
`timescale 1ns/10ps

module tb_switch;
    logic clk;
    logic rst_n;
    chiplet_types_pkg::flit_t in_flit [switch_cfg_pkg::NUM_PORTS];
    logic in_valid [switch_cfg_pkg::NUM_PORTS];
    logic out_ready [switch_cfg_pkg::NUM_PORTS];
    logic in_ready [switch_cfg_pkg::NUM_PORTS];
    chiplet_types_pkg::flit_t out_flit [switch_cfg_pkg::NUM_PORTS];
    logic out_valid [switch_cfg_pkg::NUM_PORTS];
    logic [switch_cfg_pkg::NODE_BITS-1:0] node_id;

    // Expected flits indexed by source * NUM_PORTS + output
    chiplet_types_pkg::flit_t exp_q [switch_cfg_pkg::NUM_PORTS * switch_cfg_pkg::NUM_PORTS][$];
    int gap_q[$];
    int port_q[$];
    int out_q[$];
    int hold_q[$];
    chiplet_types_pkg::flit_t flit_q[$];
    int errors = 0;
    int gap_sum = 0;
    bit loaded = 1'b0;
    int cycle = 0;
    int stall_until = 0;

    switch i_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_flit   (in_flit),
        .in_valid  (in_valid),
        .out_ready (out_ready),
        .in_ready  (in_ready),
        .out_flit  (out_flit),
        .out_valid (out_valid),
        .node_id   (node_id)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int pending();
        int total;
        total = 0;
        for (int k = 0; k < switch_cfg_pkg::NUM_PORTS * switch_cfg_pkg::NUM_PORTS; k++) begin
            total += exp_q[k].size();
        end
        return total;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            errors++;
            $display("** Error at %0t: %s = %h, expected %h", $time, name, got, expected);
        end
    endtask

    // Holds valid until the flit is taken
    // Ready is sampled at the falling edge
    task automatic send_flit(input int port, input chiplet_types_pkg::flit_t flit);
        in_flit[port] <= flit;
        in_valid[port] <= 1'b1;
        @(negedge clk);
        while (!in_ready[port]) begin
            @(negedge clk);
        end
        @(posedge clk);
        in_valid[port] <= 1'b0;
    endtask

    // Random stalls on every output while a stall window is open
    initial begin
        int unsigned rng;
        rng = 32'd68219;
        for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
            out_ready[o] <= 1'b1;
        end
        forever begin
            @(posedge clk);
            cycle <= cycle + 1;
            for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
                rng = lcg_next(rng);
                out_ready[o] <= (cycle < stall_until) ? rng[16] : 1'b1;
            end
        end
    end

    // Output monitor and scoreboard
    initial begin
        logic held [switch_cfg_pkg::NUM_PORTS];
        chiplet_types_pkg::flit_t held_flit [switch_cfg_pkg::NUM_PORTS];
        int k;
        for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
            held[o] = 1'b0;
        end
        forever begin
            @(negedge clk);
            for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
                if (!rst_n) begin
                    held[o] = 1'b0;
                end else begin
                    // A stalled flit must stay put
                    if (held[o]) begin
                        check($sformatf("out_valid[%0d]", o), 32'(out_valid[o]), 32'd1);
                        check($sformatf("out_flit[%0d]", o), out_flit[o], held_flit[o]);
                    end
                    if (out_valid[o] && out_ready[o]) begin
                        // Source port sits in bits 13:12 of a data flit
                        k = int'(out_flit[o][13:12]) * switch_cfg_pkg::NUM_PORTS + o;
                        if (exp_q[k].size() == 0) begin
                            errors++;
                            $display("At %0t an unexpected flit %h left output %0d",
                                     $time, out_flit[o], o);
                        end else begin
                            check($sformatf("out_flit[%0d]", o), out_flit[o],
                                  exp_q[k].pop_front());
                        end
                    end
                    held[o] = out_valid[o] && !out_ready[o];
                    held_flit[o] = out_flit[o];
                end
            end
        end
    end

    initial begin
        wait (loaded);
        #((gap_sum + 200) * 8);
        $display("Timeout after %0d cycles with %0d flits never seen at an output",
                 gap_sum + 200, pending());
        $display("Something failed");
        $finish;
    end

    initial begin
        int fd;
        int n;
        int gap;
        int port;
        int out_port;
        int hold;
        chiplet_types_pkg::flit_t flit;
        logic [switch_cfg_pkg::NODE_BITS-1:0] model_id;
        string line;
        model_id = '0;
        rst_n <= 1'b0;
        for (int p = 0; p < switch_cfg_pkg::NUM_PORTS; p++) begin
            in_flit[p] <= '0;
            in_valid[p] <= 1'b0;
        end
        fd = $fopen("switch_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file switch_stimulus.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%d %d %h %d %d", gap, port, flit, out_port, hold);
                if (n == 5) begin
                    gap_q.push_back(gap);
                    port_q.push_back(port);
                    flit_q.push_back(flit);
                    out_q.push_back(out_port);
                    hold_q.push_back(hold);
                    gap_sum += gap;
                end
            end
            $fclose(fd);
        end
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check("node_id", 32'(node_id), 32'd0);
        for (int o = 0; o < switch_cfg_pkg::NUM_PORTS; o++) begin
            check($sformatf("out_valid[%0d]", o), 32'(out_valid[o]), 32'd0);
            check($sformatf("in_ready[%0d]", o), 32'(in_ready[o]), 32'd1);
        end
        @(posedge clk);

        foreach (gap_q[i]) begin
            repeat (gap_q[i]) @(posedge clk);
            flit = flit_q[i];
            if (out_q[i] != 7) begin
                exp_q[int'(flit[13:12]) * switch_cfg_pkg::NUM_PORTS + out_q[i]].push_back(flit);
            end
            // Node id follows the claiming rule for config flits
            if (flit[chiplet_types_pkg::FMT_MSB:chiplet_types_pkg::FMT_LSB]
                    == chiplet_types_pkg::FMT_SWITCH_CFG
                && flit[chiplet_types_pkg::CFG_SET_ID_BIT]
                && (flit[chiplet_types_pkg::DEST_MSB:chiplet_types_pkg::DEST_LSB] == model_id
                    || model_id == '0)) begin
                model_id = flit[chiplet_types_pkg::CFG_NODE_MSB:chiplet_types_pkg::CFG_NODE_LSB];
            end
            if (hold_q[i] > 0) begin
                stall_until <= cycle + hold_q[i];
            end
            send_flit(port_q[i], flit);
        end

        while (pending() != 0) begin
            @(negedge clk);
        end
        // A few idle cycles to catch stray flits
        repeat (4) @(negedge clk);
        check("node_id", 32'(node_id), 32'(model_id));
        // Every input buffer has drained by now
        for (int p = 0; p < switch_cfg_pkg::NUM_PORTS; p++) begin
            check($sformatf("in_ready[%0d]", p), 32'(in_ready[p]), 32'd1);
        end
        $display("Run finished with %0d errors and %0d missing flits", errors, pending());
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end
endmodule
